// File: verilog/atm_cfg.svh
// ATM controller configuration
// field widths, stored card credentials and the balance loaded at reset

`ifndef ATM_CFG_SVH
`define ATM_CFG_SVH

//////////////////////////////
// field widths
//////////////////////////////
`define ATM_AMOUNT_W   32
`define ATM_PIN_W      4
`define ATM_ACCOUNT_W  16
`define ATM_OPCODE_W   4

//////////////////////////////
// stored credentials
//////////////////////////////
`define ATM_CORRECT_PIN      4'b1010
// only account accepted as a transfer destination
`define ATM_CORRECT_ACCOUNT  16'hD903

// 1,000,000 in the account after reset
`define ATM_OPENING_BALANCE  32'h000F4240

`endif

// File: verilog/atm_pkg.sv
// ATM controller types
// state and opcode encodings shared by the sequencers

`include "atm_cfg.svh"

package atm_pkg;

  // codes not listed here are ignored by the session
  typedef enum logic [`ATM_OPCODE_W-1:0] {
    OP_NONE         = 4'b0000,
    OP_VIEW_BALANCE = 4'b0001,
    OP_WITHDRAW     = 4'b0010,
    OP_DEPOSIT      = 4'b0011,
    OP_TRANSFER     = 4'b0101
  } opcode_t;

  typedef enum logic [3:0] {
    SES_IDLE, SES_INSERT_CARD, SES_CHOOSE_LANGUAGE, SES_ENTER_PIN,
    SES_CHOOSE_TRANSACTION, SES_RUN_TRANSACTION, SES_PRINT_RECEIPT,
    SES_ONE_MORE, SES_EJECT_CARD
  } session_state_t;

  typedef enum logic [3:0] {
    TXN_IDLE, TXN_VIEW_BALANCE, TXN_DEPOSIT, TXN_CONFIRM_DEPOSIT,
    TXN_WITHDRAW, TXN_ENTER_VALUE, TXN_CHECK_FUNDS, TXN_CONFIRM_WITHDRAW,
    TXN_TRANSFER_ENTRY, TXN_CHECK_TRANSFER, TXN_CONFIRM_TRANSFER
  } txn_state_t;

endpackage

// File: verilog/atm_session_fsm.sv
// ATM session sequencer
// takes a card session from insertion and PIN check to card ejection

`timescale 1ns/1ps
`include "atm_cfg.svh"

module atm_session_fsm (
  input  logic                  Clock,
  input  logic                  Reset,
  input  logic                  card_inserted,
  input  logic                  language_chosen,
  input  logic [`ATM_PIN_W-1:0] user_pin,
  input  atm_pkg::opcode_t      opcode,
  input  logic                  receipt,
  input  logic                  another_operation,
  input  logic                  txn_done,
  output logic                  txn_start,
  output atm_pkg::opcode_t      txn_opcode,
  output logic                  usage_finished
);
  import atm_pkg::*;

  session_state_t state;
  session_state_t next_state;
  logic           opcode_valid;

  always_comb begin
    case (opcode)
      OP_VIEW_BALANCE, OP_WITHDRAW, OP_DEPOSIT, OP_TRANSFER: opcode_valid = 1'b1;
      default: opcode_valid = 1'b0;
    endcase
  end

  //////////////////////////////
  // state register
  //////////////////////////////
  always_ff @(posedge Clock or negedge Reset) begin
    if (!Reset) begin
      state <= SES_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      SES_IDLE: begin
        if (card_inserted) next_state = SES_INSERT_CARD;
      end
      SES_INSERT_CARD: next_state = SES_CHOOSE_LANGUAGE;
      SES_CHOOSE_LANGUAGE: begin
        if (language_chosen) next_state = SES_ENTER_PIN;
      end
      SES_ENTER_PIN: begin
        if (user_pin == `ATM_CORRECT_PIN) next_state = SES_CHOOSE_TRANSACTION;
      end
      SES_CHOOSE_TRANSACTION: begin
        if (opcode_valid) next_state = SES_RUN_TRANSACTION;
      end
      // receipt is sampled in the same cycle as txn_done
      SES_RUN_TRANSACTION: begin
        if (txn_done) begin
          next_state = receipt ? SES_PRINT_RECEIPT : SES_ONE_MORE;
        end
      end
      SES_PRINT_RECEIPT: next_state = SES_ONE_MORE;
      SES_ONE_MORE: begin
        next_state = another_operation ? SES_CHOOSE_TRANSACTION : SES_EJECT_CARD;
      end
      SES_EJECT_CARD: next_state = SES_IDLE;
      default: next_state = SES_IDLE;
    endcase
  end

  // start lasts one cycle since the state moves on at the next edge
  assign txn_start      = (state == SES_CHOOSE_TRANSACTION) && opcode_valid;
  assign txn_opcode     = opcode;
  assign usage_finished = (state == SES_EJECT_CARD);

  //////////////////////////////
  // checks
  //////////////////////////////
  a_pin_hold: assert property (
    @(posedge Clock) disable iff (!Reset)
      (state == SES_ENTER_PIN && user_pin != `ATM_CORRECT_PIN) |=> (state == SES_ENTER_PIN)
  );

  a_one_more: assert property (
    @(posedge Clock) disable iff (!Reset)
      (state == SES_ONE_MORE && another_operation) |=> (state == SES_CHOOSE_TRANSACTION)
  );

endmodule

// File: verilog/atm_transaction_fsm.sv
// ATM transaction sequencer
// runs one view, deposit, withdraw or transfer and strobes the ledger

`timescale 1ns/1ps
`include "atm_cfg.svh"

module atm_transaction_fsm (
  input  logic                      Clock,
  input  logic                      Reset,
  input  logic                      txn_start,
  input  atm_pkg::opcode_t          txn_opcode,
  input  logic                      money_deposited,
  input  logic                      quick_list,
  input  logic                      manual_value_entered,
  input  logic [`ATM_AMOUNT_W-1:0]  deposit_value,
  input  logic [`ATM_AMOUNT_W-1:0]  withdraw_value,
  input  logic [`ATM_AMOUNT_W-1:0]  transfer_value,
  input  logic [`ATM_ACCOUNT_W-1:0] account_no,
  input  logic                      funds_ok,
  output logic                      txn_done,
  output logic [`ATM_AMOUNT_W-1:0]  ledger_amount,
  output logic                      ledger_credit,
  output logic                      ledger_debit,
  output logic                      balance_shown,
  output logic                      deposited,
  output logic                      withdrawn,
  output logic                      transferred
);
  import atm_pkg::*;

  txn_state_t state;
  txn_state_t next_state;

  always_ff @(posedge Clock or negedge Reset) begin
    if (!Reset) begin
      state <= TXN_IDLE;
    end else begin
      state <= next_state;
    end
  end

  //////////////////////////////
  // next state
  //////////////////////////////
  always_comb begin
    next_state = state;
    case (state)
      TXN_IDLE: begin
        if (txn_start) begin
          case (txn_opcode)
            OP_VIEW_BALANCE: next_state = TXN_VIEW_BALANCE;
            OP_DEPOSIT:      next_state = TXN_DEPOSIT;
            OP_WITHDRAW:     next_state = TXN_WITHDRAW;
            OP_TRANSFER:     next_state = TXN_TRANSFER_ENTRY;
            default:         next_state = TXN_IDLE;
          endcase
        end
      end
      TXN_DEPOSIT: begin
        if (money_deposited) next_state = TXN_CONFIRM_DEPOSIT;
      end
      TXN_WITHDRAW: begin
        next_state = quick_list ? TXN_CHECK_FUNDS : TXN_ENTER_VALUE;
      end
      TXN_ENTER_VALUE: begin
        if (manual_value_entered) next_state = TXN_CHECK_FUNDS;
      end
      // short of funds goes back for a new amount
      TXN_CHECK_FUNDS: begin
        next_state = funds_ok ? TXN_CONFIRM_WITHDRAW : TXN_WITHDRAW;
      end
      TXN_TRANSFER_ENTRY: begin
        if (account_no == `ATM_CORRECT_ACCOUNT) next_state = TXN_CHECK_TRANSFER;
      end
      TXN_CHECK_TRANSFER: begin
        next_state = funds_ok ? TXN_CONFIRM_TRANSFER : TXN_TRANSFER_ENTRY;
      end
      TXN_VIEW_BALANCE, TXN_CONFIRM_DEPOSIT, TXN_CONFIRM_WITHDRAW, TXN_CONFIRM_TRANSFER: begin
        next_state = TXN_IDLE;
      end
      default: next_state = TXN_IDLE;
    endcase
  end

  // amount follows the value that the current state works on
  always_comb begin
    case (state)
      TXN_DEPOSIT, TXN_CONFIRM_DEPOSIT: ledger_amount = deposit_value;
      TXN_WITHDRAW, TXN_ENTER_VALUE, TXN_CHECK_FUNDS, TXN_CONFIRM_WITHDRAW: begin
        ledger_amount = withdraw_value;
      end
      TXN_TRANSFER_ENTRY, TXN_CHECK_TRANSFER, TXN_CONFIRM_TRANSFER: begin
        ledger_amount = transfer_value;
      end
      default: ledger_amount = '0;
    endcase
  end

  assign balance_shown = (state == TXN_VIEW_BALANCE);
  assign deposited     = (state == TXN_CONFIRM_DEPOSIT);
  assign withdrawn     = (state == TXN_CONFIRM_WITHDRAW);
  assign transferred   = (state == TXN_CONFIRM_TRANSFER);
  assign txn_done      = balance_shown || deposited || withdrawn || transferred;
  assign ledger_credit = deposited;
  assign ledger_debit  = withdrawn || transferred;

  a_manual_entry: assert property (
    @(posedge Clock) disable iff (!Reset)
      (state == TXN_ENTER_VALUE && manual_value_entered) |=> (state == TXN_CHECK_FUNDS)
  );

  a_quick_list: assert property (
    @(posedge Clock) disable iff (!Reset)
      (state == TXN_WITHDRAW && quick_list) |=> (state == TXN_CHECK_FUNDS)
  );

endmodule

// File: verilog/atm_ledger.sv
// ATM account ledger
// holds the balance, applies credits and debits, compares amounts to funds

`timescale 1ns/1ps
`include "atm_cfg.svh"

module atm_ledger (
  input  logic                     Clock,
  input  logic                     Reset,
  input  logic [`ATM_AMOUNT_W-1:0] ledger_amount,
  input  logic                     ledger_credit,
  input  logic                     ledger_debit,
  output logic                     funds_ok,
  output logic [`ATM_AMOUNT_W-1:0] balance
);

  //////////////////////////////
  // balance register
  //////////////////////////////
  always_ff @(posedge Clock or negedge Reset) begin
    if (!Reset) begin
      balance <= `ATM_OPENING_BALANCE;
    end else if (ledger_credit) begin
      balance <= balance + ledger_amount;
    end else if (ledger_debit) begin
      balance <= balance - ledger_amount;
    end
  end

  // an amount equal to the balance is still allowed
  assign funds_ok = (ledger_amount <= balance);

  // funds were checked one cycle earlier, so the debit must still fit
  a_debit_funded: assert property (
    @(posedge Clock) disable iff (!Reset)
      ledger_debit |-> funds_ok
  );

  a_one_strobe: assert property (
    @(posedge Clock) disable iff (!Reset)
      !(ledger_credit && ledger_debit)
  );

endmodule

// File: verilog/atm_top.sv
// ATM controller top level
// session sequencer, transaction sequencer and ledger

`timescale 1ns/1ps
`include "atm_cfg.svh"

module atm_top (
  input  logic                      Clock,
  input  logic                      Reset,
  input  logic                      card_inserted,
  input  logic                      language_chosen,
  input  logic [`ATM_PIN_W-1:0]     user_pin,
  input  atm_pkg::opcode_t          opcode,
  input  logic                      receipt,
  input  logic                      another_operation,
  input  logic                      money_deposited,
  input  logic                      quick_list,
  input  logic                      manual_value_entered,
  input  logic [`ATM_AMOUNT_W-1:0]  deposit_value,
  input  logic [`ATM_AMOUNT_W-1:0]  withdraw_value,
  input  logic [`ATM_AMOUNT_W-1:0]  transfer_value,
  input  logic [`ATM_ACCOUNT_W-1:0] account_no,
  output logic                      usage_finished,
  output logic                      balance_shown,
  output logic                      deposited,
  output logic                      withdrawn,
  output logic                      transferred,
  output logic [`ATM_AMOUNT_W-1:0]  balance
);
  import atm_pkg::*;

  logic                     txn_start;
  opcode_t                  txn_opcode;
  logic                     txn_done;
  logic [`ATM_AMOUNT_W-1:0] ledger_amount;
  logic                     ledger_credit;
  logic                     ledger_debit;
  logic                     funds_ok;

  atm_session_fsm session_i (
    .Clock             (Clock),
    .Reset             (Reset),
    .card_inserted     (card_inserted),
    .language_chosen   (language_chosen),
    .user_pin          (user_pin),
    .opcode            (opcode),
    .receipt           (receipt),
    .another_operation (another_operation),
    .txn_done          (txn_done),
    .txn_start         (txn_start),
    .txn_opcode        (txn_opcode),
    .usage_finished    (usage_finished)
  );

  atm_transaction_fsm txn_i (
    .Clock                (Clock),
    .Reset                (Reset),
    .txn_start            (txn_start),
    .txn_opcode           (txn_opcode),
    .money_deposited      (money_deposited),
    .quick_list           (quick_list),
    .manual_value_entered (manual_value_entered),
    .deposit_value        (deposit_value),
    .withdraw_value       (withdraw_value),
    .transfer_value       (transfer_value),
    .account_no           (account_no),
    .funds_ok             (funds_ok),
    .txn_done             (txn_done),
    .ledger_amount        (ledger_amount),
    .ledger_credit        (ledger_credit),
    .ledger_debit         (ledger_debit),
    .balance_shown        (balance_shown),
    .deposited            (deposited),
    .withdrawn            (withdrawn),
    .transferred          (transferred)
  );

  atm_ledger ledger_i (
    .Clock         (Clock),
    .Reset         (Reset),
    .ledger_amount (ledger_amount),
    .ledger_credit (ledger_credit),
    .ledger_debit  (ledger_debit),
    .funds_ok      (funds_ok),
    .balance       (balance)
  );

endmodule

// File: verif/atm_tb.sv
// ATM controller testbench
// replays stimulus records through card sessions and checks the flags and the balance

`timescale 1ns/1ps
`include "atm_cfg.svh"

module atm_tb;
  import atm_pkg::*;

  localparam int FIELDS = 9;
  localparam int MAX_RECORDS = 32;

  logic Clock = 1'b0;
  logic Reset = 1'b0;
  logic card_inserted = 1'b0;
  logic language_chosen = 1'b0;
  logic receipt = 1'b0;
  logic another_operation = 1'b0;
  logic money_deposited = 1'b0;
  logic quick_list = 1'b0;
  logic manual_value_entered = 1'b0;
  logic [`ATM_PIN_W-1:0] user_pin = '0;
  opcode_t opcode = OP_NONE;
  logic [`ATM_AMOUNT_W-1:0] deposit_value = '0;
  logic [`ATM_AMOUNT_W-1:0] withdraw_value = '0;
  logic [`ATM_AMOUNT_W-1:0] transfer_value = '0;
  logic [`ATM_ACCOUNT_W-1:0] account_no = '0;
  logic usage_finished, balance_shown, deposited, withdrawn, transferred;
  logic [`ATM_AMOUNT_W-1:0] balance;

  logic [31:0]              stim_mem [0:FIELDS*MAX_RECORDS-1];
  logic [`ATM_AMOUNT_W-1:0] model_balance;
  int                       num_records = 0;
  int                       value_errors = 0;
  int                       missing_flags = 0;
  int                       seed = 6;
  bit                       loaded = 1'b0;
  bit                       in_session = 1'b0;

  always #20 Clock = ~Clock;

  atm_top atm_top_i (.*);

  function automatic logic flag_of(input logic [3:0] code);
    case (code)
      4'd1: return balance_shown;
      4'd2: return deposited;
      4'd3: return withdrawn;
      default: return transferred;
    endcase
  endfunction

  task automatic check_value(input logic ok, input string what);
    assert (ok) else begin
      $display("ERR %0t: %s", $time, what);
      value_errors++;
    end
  endtask

  task automatic wait_flag(input logic [3:0] code);
    int cycles;
    cycles = 0;
    while (!flag_of(code) && cycles < 20) begin
      @(negedge Clock);
      cycles++;
    end
    assert (flag_of(code)) else begin
      $display("Missing flag: flag code %0d did not rise within 20 cycles", code);
      missing_flags++;
    end
  endtask

  //////////////////////////////
  // session steps
  //////////////////////////////
  // drives card, language and PIN up to the falling edge in SES_CHOOSE_TRANSACTION
  task automatic start_session(input int wrong_pins, input logic [3:0] op);
    logic [31:0] rnd;
    opcode = opcode_t'(op);
    card_inserted = 1'b1;
    @(negedge Clock);
    card_inserted = 1'b0;
    @(negedge Clock);
    language_chosen = 1'b1;
    @(negedge Clock);
    language_chosen = 1'b0;
    repeat (wrong_pins) begin
      rnd = $random(seed);
      user_pin = rnd[3:0];
      if (user_pin == `ATM_CORRECT_PIN) user_pin = user_pin ^ 4'b0001;
      @(negedge Clock);
      check_value(!(balance_shown || deposited || withdrawn || transferred),
                  "transaction flag raised with a wrong PIN");
    end
    user_pin = `ATM_CORRECT_PIN;
    @(negedge Clock);
    user_pin = '0;
  endtask

  task automatic run_record(input int base);
    logic [3:0]  op;
    logic [3:0]  code;
    logic [31:0] amount;
    logic [31:0] retry;
    op = stim_mem[base][3:0];
    amount = stim_mem[base+1];
    retry = stim_mem[base+2];
    code = stim_mem[base+8][3:0];
    opcode = opcode_t'(op);
    deposit_value = amount;
    withdraw_value = amount;
    transfer_value = amount;
    account_no = stim_mem[base+3][`ATM_ACCOUNT_W-1:0];
    quick_list = stim_mem[base+4][0];
    receipt = stim_mem[base+5][0];
    another_operation = stim_mem[base+6][0];
    manual_value_entered = (op == OP_WITHDRAW) && !quick_list;
    @(negedge Clock);
    opcode = OP_NONE;
    if (op == OP_DEPOSIT) begin
      money_deposited = 1'b1;
      @(negedge Clock);
      money_deposited = 1'b0;
    end
    // refused amount or wrong account keeps the flag low until corrected
    if (retry != 0 || (op == OP_TRANSFER && account_no != `ATM_CORRECT_ACCOUNT)) begin
      repeat (8) begin
        check_value(!flag_of(code), "flag raised before the request was corrected");
        @(negedge Clock);
      end
      if (retry != 0) begin
        amount = retry;
        withdraw_value = retry;
        transfer_value = retry;
      end
      account_no = `ATM_CORRECT_ACCOUNT;
    end
    wait_flag(code);
    check_value($countones({balance_shown, deposited, withdrawn, transferred}) == 1,
                "wrong set of flags high");
    check_value(balance == model_balance,
                $sformatf("balance %0d, expected %0d", balance, model_balance));
    if (op == OP_DEPOSIT) model_balance = model_balance + amount;
    else if (op == OP_WITHDRAW || op == OP_TRANSFER) model_balance = model_balance - amount;
    @(negedge Clock);
    check_value(!flag_of(code), "flag high for more than one cycle");
    check_value(balance == model_balance,
                $sformatf("balance %0d after update, expected %0d", balance, model_balance));
    quick_list = 1'b0;
    manual_value_entered = 1'b0;
    if (receipt) @(negedge Clock);
    @(negedge Clock);
    if (!another_operation) begin
      check_value(usage_finished, "usage_finished missing at card ejection");
      @(negedge Clock);
      check_value(!usage_finished, "usage_finished high for more than one cycle");
    end else begin
      check_value(!usage_finished, "usage_finished raised while the session goes on");
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    for (int i = 0; i < FIELDS*MAX_RECORDS; i++) stim_mem[i] = '1;
    $readmemh("verif/atm_stim.txt", stim_mem);
    while (num_records < MAX_RECORDS && stim_mem[num_records*FIELDS] != 32'hFFFF_FFFF) begin
      num_records++;
    end
    loaded = 1'b1;
    model_balance = `ATM_OPENING_BALANCE;
    repeat (3) @(posedge Clock);
    @(negedge Clock);
    Reset = 1'b1;
    @(negedge Clock);
    check_value(!(balance_shown || deposited || withdrawn || transferred || usage_finished),
                "flag high after reset");
    check_value(balance == `ATM_OPENING_BALANCE, "balance after reset");
    for (int r = 0; r < num_records; r++) begin
      if (!in_session) start_session(stim_mem[r*FIELDS+7], stim_mem[r*FIELDS][3:0]);
      run_record(r*FIELDS);
      in_session = another_operation;
    end
    $display("value errors: %0d, missing flags: %0d", value_errors, missing_flags);
    if (value_errors == 0 && missing_flags == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog allows 60 cycles per record
  initial begin
    wait (loaded);
    #(num_records * 60 * 40);
    $display("Timeout: the records did not complete within %0d cycles", num_records * 60);
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: verif/atm_stim.txt
// op amount retry_amount account quick_list receipt another wrong_pins flag
// flag 1 balance_shown, 2 deposited, 3 withdrawn, 4 transferred; op ffffffff ends
1 00000000 00000000 0000 0 1 1 3 1
3 00001388 00000000 0000 0 0 1 0 2
1 00000000 00000000 0000 0 0 1 0 1
2 000007d0 00000000 0000 1 1 1 0 3
2 00000bb8 00000000 0000 0 0 1 0 3
2 00ffffff 000001f4 0000 1 0 1 0 3
5 00002710 00000000 1234 0 1 1 0 4
1 00000000 00000000 0000 0 1 0 0 1
5 001e8480 000003e8 d903 0 0 1 2 4
2 00100000 00000064 0000 0 0 1 0 3
3 0000c350 00000000 0000 0 1 0 0 2
1 00000000 00000000 0000 0 0 0 0 1
ffffffff 00000000 00000000 0000 0 0 0 0 0

// File: filelist.f
+incdir+verilog
verilog/atm_pkg.sv
verilog/atm_session_fsm.sv
verilog/atm_transaction_fsm.sv
verilog/atm_ledger.sv
verilog/atm_top.sv
verif/atm_tb.sv

// File: Makefile
sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f filelist.f --top-module atm_tb -Mdir obj_dir
	./obj_dir/Vatm_tb | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
